//--- Makefile
VERILATOR ?= verilator
TOP       := tb_mem_subsys
FILELIST  := build.f
VFLAGS    := --binary --timing --assert
LINTFLAGS := --lint-only --timing -Wall
OBJDIR    := obj_dir
LOG       := sim.log
FAIL_MSG  := Done: errors found
PASS_MSG  := Done: no errors

.PHONY: all lint clean

all: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "simulation ended early"; exit 1; }

$(OBJDIR)/V$(TOP): $(FILELIST) $(wildcard *.sv)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- addr_region_decoder.sv
`timescale 1ns/1ps

module addr_region_decoder (
    input  logic                  [2:0] addr_hi_i,
    input  logic                        mem_rd_i,
    input  logic                        mem_wr_i,
    output mem_stage_pkg::region_t      region_o,
    output logic                        mem_rd_o,
    output logic                        mem_wr_o,
    output logic                        io_rd_o,
    output logic                        io_wr_o
);
    import mem_stage_pkg::*;

    logic is_mem;

    // everything outside the two peripheral codes is data memory
    always_comb begin
        case (addr_hi_i)
            IO_SEL:    region_o = REG_IO;
            TIMER_SEL: region_o = REG_TIMER;
            default:   region_o = REG_MEM;
        endcase
    end

    assign is_mem = (region_o == REG_MEM);

    // each strobe goes to exactly one target
    assign mem_rd_o = mem_rd_i && is_mem;
    assign mem_wr_o = mem_wr_i && is_mem;
    assign io_rd_o  = mem_rd_i && !is_mem;
    assign io_wr_o  = mem_wr_i && !is_mem;

endmodule

//--- build.f
mem_stage_pkg.sv
mem_req_if.sv
addr_region_decoder.sv
data_mem_ctrl.sv
io_timer_regs.sv
mem_stage.sv
mem_subsys_top.sv
tb_mem_subsys.sv

//--- data_mem_ctrl.sv
`timescale 1ns/1ps

module data_mem_ctrl #(
    parameter int MEM_DEPTH_WORDS = 1024,
    parameter int MEM_LATENCY     = 3
) (
    input  logic    clk_i,
    input  logic    rst_i,
    mem_req_if.ctrl bus
);
    import mem_stage_pkg::*;

    localparam int AW    = (MEM_DEPTH_WORDS > 1) ? $clog2(MEM_DEPTH_WORDS) : 1;
    localparam int CNT_W = (MEM_LATENCY > 2) ? $clog2(MEM_LATENCY) : 1;

    // last busy count before the completion cycle
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'((MEM_LATENCY > 1) ? MEM_LATENCY - 2 : 0);

    typedef enum logic [1:0] {
        IDLE,
        BUSY,
        DONE
    } state_t;

    state_t           state_q;
    logic [CNT_W-1:0] cnt_q;
    logic             access;

    logic [XLEN-1:0]  mem_q [MEM_DEPTH_WORDS];
    logic [AW-1:0]    word_idx;
    logic [XLEN-1:0]  word_rd;
    logic [3:0]       byte_en;
    logic [XLEN-1:0]  wdata_lane;
    logic [7:0]       ld_byte;
    logic [15:0]      ld_half;

    assign access   = bus.rd || bus.wr;
    assign word_idx = bus.addr[AW+1:2];

    // idle -> busy (MEM_LATENCY-1 cycles) -> done -> idle
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    cnt_q <= '0;
                    if (access) begin
                        state_q <= (MEM_LATENCY > 1) ? BUSY : DONE;
                    end
                end
                BUSY: begin
                    if (cnt_q == CNT_LAST) begin
                        state_q <= DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // store lanes, data replicated so any enabled lane picks the right bits
    always_comb begin
        byte_en    = 4'b0000;
        wdata_lane = bus.wdata;
        case (bus.op)
            OP_SB: begin
                byte_en    = 4'b0001 << bus.addr[1:0];
                wdata_lane = {4{bus.wdata[7:0]}};
            end
            OP_SH: begin
                byte_en    = bus.addr[1] ? 4'b1100 : 4'b0011;
                wdata_lane = {2{bus.wdata[15:0]}};
            end
            OP_SW: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    // write commits in the completion cycle
    always_ff @(posedge clk_i) begin
        if ((state_q == DONE) && bus.wr) begin
            for (int i = 0; i < 4; i++) begin
                if (byte_en[i]) begin
                    mem_q[word_idx][8*i +: 8] <= wdata_lane[8*i +: 8];
                end
            end
        end
    end

    // load lane select and extension
    assign word_rd = mem_q[word_idx];
    assign ld_byte = word_rd[{bus.addr[1:0], 3'b000} +: 8];
    assign ld_half = bus.addr[1] ? word_rd[31:16] : word_rd[15:0];

    always_comb begin
        case (bus.op)
            OP_LB:   bus.rdata = {{24{ld_byte[7]}}, ld_byte};
            OP_LBU:  bus.rdata = {24'd0, ld_byte};
            OP_LH:   bus.rdata = {{16{ld_half[15]}}, ld_half};
            OP_LHU:  bus.rdata = {16'd0, ld_half};
            default: bus.rdata = word_rd;
        endcase
    end

    assign bus.ctrl_ready  = (state_q == DONE);
    assign bus.rdata_valid = (state_q == DONE) && bus.rd;

    // the stage never issues both strobes
    a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (!rst_i)
        !(bus.rd && bus.wr))
        else $error("data_mem_ctrl: rd and wr high together");

    // request must be held until completion
    a_addr_hold: assert property (@(posedge clk_i) disable iff (!rst_i)
        (state_q == BUSY) |-> $stable(bus.addr))
        else $error("data_mem_ctrl: addr changed while busy");

endmodule

//--- io_timer_regs.sv
`timescale 1ns/1ps

module io_timer_regs (
    input  logic                                clk_i,
    input  logic                                rst_i,
    input  mem_stage_pkg::region_t              region_i,
    input  logic                                io_rd_i,
    input  logic                                io_wr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]      wdata_i,
    input  mem_stage_pkg::ls_op_t               op_i,
    output logic [mem_stage_pkg::XLEN-1:0]      io_rdata_o,
    output logic                                io_valid_o,
    output logic [mem_stage_pkg::XLEN-1:0]      gpio_o
);
    import mem_stage_pkg::*;

    logic [XLEN-1:0] timer_q;
    logic [XLEN-1:0] gpio_q;

    // free-running cycle counter
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            timer_q <= '0;
        end else begin
            timer_q <= timer_q + 1'b1;
        end
    end

    // output port written as a full word
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            gpio_q <= '0;
        end else if (io_wr_i && (region_i == REG_IO)) begin
            gpio_q <= wdata_i;
        end
    end

    // reads answer in the same cycle
    assign io_rdata_o = (region_i == REG_TIMER) ? timer_q : gpio_q;
    assign io_valid_o = io_rd_i;
    assign gpio_o     = gpio_q;

    // strobe and op kind must agree coming out of the stage
    a_wr_is_store: assert property (@(posedge clk_i) disable iff (!rst_i)
        io_wr_i |-> (op_i inside {OP_SB, OP_SH, OP_SW}))
        else $error("io_timer_regs: write strobe with non-store op");

    a_rd_is_load: assert property (@(posedge clk_i) disable iff (!rst_i)
        io_rd_i |-> !(op_i inside {OP_SB, OP_SH, OP_SW}))
        else $error("io_timer_regs: read strobe with store op");

endmodule

//--- mem_req_if.sv
`timescale 1ns/1ps

interface mem_req_if;
    import mem_stage_pkg::*;

    // request side, held by the stage until ctrl_ready
    logic            rd;
    logic            wr;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
    ls_op_t          op;

    // response side, valid in the completion cycle only
    logic [XLEN-1:0] rdata;
    logic            rdata_valid;
    logic            ctrl_ready;

    modport stage (
        output rd, wr, addr, wdata, op,
        input  rdata, rdata_valid, ctrl_ready
    );

    modport ctrl (
        input  rd, wr, addr, wdata, op,
        output rdata, rdata_valid, ctrl_ready
    );

endinterface

//--- mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic                                    clk_i,
    input  logic                                    rst_i,

    // from execute
    input  logic [mem_stage_pkg::XLEN-1:0]          wb_data_i,
    input  logic                                    wb_en_i,
    input  logic [mem_stage_pkg::RF_ADDR_W-1:0]     rd_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]          mem_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]          mem_wdata_i,
    input  mem_stage_pkg::ls_op_t                   ls_op_i,
    input  logic                                    mem_rd_i,
    input  logic                                    mem_wr_i,

    // to writeback
    output logic [mem_stage_pkg::XLEN-1:0]          wb_data_o,
    output logic                                    wb_en_o,
    output logic [mem_stage_pkg::RF_ADDR_W-1:0]     rd_addr_o,
    output logic                                    load_o,
    output logic                                    load_valid_o,
    output logic [mem_stage_pkg::XLEN-1:0]          load_data_o,
    output logic                                    stall_o,

    // data memory controller
    mem_req_if.stage                                bus,

    // io and timer block
    output logic                                    io_rd_o,
    output logic                                    io_wr_o,
    output mem_stage_pkg::region_t                  io_region_o,
    output logic [mem_stage_pkg::XLEN-1:0]          io_wdata_o,
    output mem_stage_pkg::ls_op_t                   io_op_o,
    input  logic [mem_stage_pkg::XLEN-1:0]          io_rdata_i,
    input  logic                                    io_valid_i
);
    import mem_stage_pkg::*;

    logic mem_rd_w;
    logic mem_wr_w;

    addr_region_decoder u_addr_region_decoder (
        .addr_hi_i (mem_addr_i[30:28]),
        .mem_rd_i  (mem_rd_i),
        .mem_wr_i  (mem_wr_i),
        .region_o  (io_region_o),
        .mem_rd_o  (mem_rd_w),
        .mem_wr_o  (mem_wr_w),
        .io_rd_o   (io_rd_o),
        .io_wr_o   (io_wr_o)
    );

    // request held by upstream while stalled
    assign bus.rd    = mem_rd_w;
    assign bus.wr    = mem_wr_w;
    assign bus.addr  = mem_addr_i;
    assign bus.wdata = mem_wdata_i;
    assign bus.op    = ls_op_i;

    assign io_wdata_o = mem_wdata_i;
    assign io_op_o    = ls_op_i;

    // pending memory access not yet completed
    assign stall_o = (mem_rd_w || mem_wr_w) && !bus.ctrl_ready;

    // control fields take a bubble on stall
    always_ff @(posedge clk_i) begin
        if (!rst_i) begin
            wb_en_o      <= 1'b0;
            load_o       <= 1'b0;
            load_valid_o <= 1'b0;
        end else if (stall_o) begin
            wb_en_o <= 1'b0;
        end else begin
            wb_en_o      <= wb_en_i;
            load_o       <= mem_rd_i;
            load_valid_o <= bus.rdata_valid || io_valid_i;
        end
    end

    // payload held while stalled
    always_ff @(posedge clk_i) begin
        if (!stall_o) begin
            wb_data_o   <= wb_data_i;
            rd_addr_o   <= rd_addr_i;
            load_data_o <= bus.rdata_valid ? bus.rdata : io_rdata_i;
        end
    end

    // peripherals answer at once and never hold the pipe
    a_no_io_stall: assert property (@(posedge clk_i) disable iff (!rst_i)
        ((mem_rd_i || mem_wr_i) &&
         (mem_addr_i[30:28] == IO_SEL || mem_addr_i[30:28] == TIMER_SEL))
        |-> !stall_o)
        else $error("mem_stage: stall raised during io access");

endmodule

//--- mem_stage_pkg.sv
package mem_stage_pkg;

    // datapath widths
    localparam int XLEN      = 32;
    localparam int RF_ADDR_W = 5;

    // codes on address bits 30:28
    localparam logic [2:0] IO_SEL    = 3'b010;
    localparam logic [2:0] TIMER_SEL = 3'b011;

    // load/store kind carried from execute
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,
        OP_LH  = 3'd1,
        OP_LW  = 3'd2,
        OP_LBU = 3'd3,
        OP_LHU = 3'd4,
        OP_SB  = 3'd5,
        OP_SH  = 3'd6,
        OP_SW  = 3'd7
    } ls_op_t;

    // target of an access
    typedef enum logic [1:0] {
        REG_MEM   = 2'd0,
        REG_IO    = 2'd1,
        REG_TIMER = 2'd2
    } region_t;

endpackage

//--- mem_subsys_top.sv
`timescale 1ns/1ps

module mem_subsys_top #(
    parameter int MEM_DEPTH_WORDS = 1024,
    parameter int MEM_LATENCY     = 3
) (
    input  logic                                    clk_i,
    input  logic                                    rst_i,
    input  logic [mem_stage_pkg::XLEN-1:0]          wb_data_i,
    input  logic                                    wb_en_i,
    input  logic [mem_stage_pkg::RF_ADDR_W-1:0]     rd_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]          mem_addr_i,
    input  logic [mem_stage_pkg::XLEN-1:0]          mem_wdata_i,
    input  mem_stage_pkg::ls_op_t                   ls_op_i,
    input  logic                                    mem_rd_i,
    input  logic                                    mem_wr_i,
    output logic [mem_stage_pkg::XLEN-1:0]          wb_data_o,
    output logic                                    wb_en_o,
    output logic [mem_stage_pkg::RF_ADDR_W-1:0]     rd_addr_o,
    output logic                                    load_o,
    output logic                                    load_valid_o,
    output logic [mem_stage_pkg::XLEN-1:0]          load_data_o,
    output logic [mem_stage_pkg::XLEN-1:0]          gpio_o,
    output logic                                    stall_o
);
    import mem_stage_pkg::*;

    logic            io_rd_w;
    logic            io_wr_w;
    region_t         io_region_w;
    logic [XLEN-1:0] io_wdata_w;
    ls_op_t          io_op_w;
    logic [XLEN-1:0] io_rdata_w;
    logic            io_valid_w;

    mem_req_if u_mem_req_if ();

    mem_stage u_mem_stage (
        .clk_i, .rst_i,
        .wb_data_i, .wb_en_i, .rd_addr_i, .mem_addr_i, .mem_wdata_i,
        .ls_op_i, .mem_rd_i, .mem_wr_i,
        .wb_data_o, .wb_en_o, .rd_addr_o, .load_o, .load_valid_o,
        .load_data_o, .stall_o,
        .bus         (u_mem_req_if.stage),
        .io_rd_o     (io_rd_w),
        .io_wr_o     (io_wr_w),
        .io_region_o (io_region_w),
        .io_wdata_o  (io_wdata_w),
        .io_op_o     (io_op_w),
        .io_rdata_i  (io_rdata_w),
        .io_valid_i  (io_valid_w)
    );

    data_mem_ctrl #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS),
        .MEM_LATENCY     (MEM_LATENCY)
    ) u_data_mem_ctrl (
        .clk_i, .rst_i,
        .bus (u_mem_req_if.ctrl)
    );

    io_timer_regs u_io_timer_regs (
        .clk_i, .rst_i,
        .region_i   (io_region_w),
        .io_rd_i    (io_rd_w),
        .io_wr_i    (io_wr_w),
        .wdata_i    (io_wdata_w),
        .op_i       (io_op_w),
        .io_rdata_o (io_rdata_w),
        .io_valid_o (io_valid_w),
        .gpio_o
    );

endmodule

//--- tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys;
    import mem_stage_pkg::*;

    localparam int MEM_DEPTH_WORDS = 1024;
    localparam int MEM_LATENCY     = 3;
    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 5;
    localparam int N_WORDS         = 16;
    localparam int N_RANDOM        = 300;
    localparam int N_OPS           = N_WORDS + 3 + N_RANDOM;
    localparam int TIMEOUT_NS      =
        (RESET_CYCLES + N_OPS * (MEM_LATENCY + 2) + 50) * CLK_PERIOD;

    logic                 clk_i;
    logic                 rst_i;
    logic [XLEN-1:0]      wb_data_i;
    logic                 wb_en_i;
    logic [RF_ADDR_W-1:0] rd_addr_i;
    logic [XLEN-1:0]      mem_addr_i;
    logic [XLEN-1:0]      mem_wdata_i;
    ls_op_t               ls_op_i;
    logic                 mem_rd_i;
    logic                 mem_wr_i;
    logic [XLEN-1:0]      wb_data_o;
    logic                 wb_en_o;
    logic [RF_ADDR_W-1:0] rd_addr_o;
    logic                 load_o;
    logic                 load_valid_o;
    logic [XLEN-1:0]      load_data_o;
    logic [XLEN-1:0]      gpio_o;
    logic                 stall_o;

    // reference model state
    logic [31:0] mem_model [N_WORDS];
    logic [31:0] gpio_model;
    logic [31:0] cycle_count;
    logic [31:0] lfsr_state;

    mem_subsys_top #(
        .MEM_DEPTH_WORDS (MEM_DEPTH_WORDS),
        .MEM_LATENCY     (MEM_LATENCY)
    ) u_mem_subsys_top (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // counts rising edges since reset release like the timer
    initial begin
        cycle_count = '0;
        forever begin
            @(posedge clk_i);
            if (rst_i) begin
                cycle_count = cycle_count + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog: test sequence not finished after %0d ns", TIMEOUT_NS);
        $display("Done: errors found");
        $fatal(1, "timeout");
    end

    // galois lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[ERROR] t=%0d ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
            $display("Done: errors found");
            $fatal(1, "check failed: %s", what);
        end
    endtask

    // lane at byte offset off then extended
    function automatic logic [31:0] expected_load(input logic [31:0] word,
                                                  input logic [1:0] off, input ls_op_t op);
        logic [31:0] sh;
        sh = word >> {off, 3'b000};
        case (op)
            OP_LB:   return {{24{sh[7]}}, sh[7:0]};
            OP_LBU:  return {24'h0, sh[7:0]};
            OP_LH:   return {{16{sh[15]}}, sh[15:0]};
            OP_LHU:  return {16'h0, sh[15:0]};
            default: return word;
        endcase
    endfunction

    // byte k of the store data lands in byte off+k
    function automatic logic [31:0] stored_word(input logic [31:0] word,
                                                input logic [1:0] off, input ls_op_t op,
                                                input logic [31:0] data);
        int size;
        int lane;
        size = (op == OP_SB) ? 1 : ((op == OP_SH) ? 2 : 4);
        for (int i = 0; i < 4; i++) begin
            lane = i - int'(off);
            if (lane >= 0 && lane < size) begin
                word[8*i +: 8] = data[8*lane +: 8];
            end
        end
        return word;
    endfunction

    // present at a falling edge then follow the stall and check the writeback
    task automatic run_op(input logic rd, input logic wr, input logic [31:0] addr,
                          input logic [31:0] wdata, input ls_op_t op,
                          input int exp_stalls, input logic [31:0] exp_load);
        logic        en;
        logic [4:0]  rda;
        logic [31:0] wbd;
        int          stalls;
        en          = 1'(rand_bits(1));
        rda         = 5'(rand_bits(5));
        wbd         = rand_bits(32);
        wb_en_i     = en;
        rd_addr_i   = rda;
        wb_data_i   = wbd;
        mem_addr_i  = addr;
        mem_wdata_i = wdata;
        ls_op_i     = op;
        mem_rd_i    = rd;
        mem_wr_i    = wr;
        stalls      = 0;
        #(CLK_PERIOD / 4);
        while (stall_o) begin
            stalls++;
            @(negedge clk_i);
            #(CLK_PERIOD / 4);
            check_val("wb_en_o in stall", 32'(wb_en_o), 32'h0);
        end
        check_val("stall cycles", 32'(stalls), 32'(exp_stalls));
        @(negedge clk_i);
        check_val("wb_en_o", 32'(wb_en_o), 32'(en));
        check_val("wb_data_o", wb_data_o, wbd);
        check_val("rd_addr_o", 32'(rd_addr_o), 32'(rda));
        check_val("load_o", 32'(load_o), 32'(rd));
        check_val("load_valid_o", 32'(load_valid_o), 32'(rd));
        if (rd) begin
            check_val("load_data_o", load_data_o, exp_load);
        end
        check_val("gpio_o", gpio_o, gpio_model);
    endtask

    task automatic random_mem_op();
        ls_op_t      op;
        int          idx;
        logic [1:0]  off;
        logic [2:0]  hi;
        logic [31:0] data;
        logic [31:0] addr;
        op   = ls_op_t'(3'(rand_bits(3)));
        idx  = int'(rand_bits(4));
        off  = 2'(rand_bits(2));
        hi   = 3'(rand_bits(3));
        data = rand_bits(32);
        if (op inside {OP_LH, OP_LHU, OP_SH}) off[0] = 1'b0;
        if (op inside {OP_LW, OP_SW}) off = 2'b00;
        // stay in the memory region
        if (hi == IO_SEL || hi == TIMER_SEL) hi = 3'b000;
        addr = {1'b0, hi, 20'h0, 6'(idx), off};
        if (op inside {OP_SB, OP_SH, OP_SW}) begin
            mem_model[idx] = stored_word(mem_model[idx], off, op, data);
            run_op(1'b0, 1'b1, addr, data, op, MEM_LATENCY, 32'h0);
        end else begin
            run_op(1'b1, 1'b0, addr, data, op, MEM_LATENCY,
                   expected_load(mem_model[idx], off, op));
        end
    endtask

    task automatic io_access(input logic is_timer, input logic is_write);
        logic [31:0] addr;
        logic [31:0] data;
        ls_op_t      wop;
        addr = {1'b0, (is_timer ? TIMER_SEL : IO_SEL), 28'(rand_bits(28))};
        data = rand_bits(32);
        // gpio takes the full word even for a byte store
        wop  = rand_bits(1) ? OP_SW : OP_SB;
        if (is_write) begin
            if (!is_timer) gpio_model = data;
            run_op(1'b0, 1'b1, addr, data, wop, 0, 32'h0);
        end else begin
            run_op(1'b1, 1'b0, addr, data, OP_LW, 0, is_timer ? cycle_count : gpio_model);
        end
    endtask

    initial begin
        logic [31:0] a;
        logic [31:0] d;
        logic        t;
        lfsr_state  = 32'h0878_ecde;
        gpio_model  = '0;
        rst_i       = 1'b0;
        wb_data_i   = '0;
        wb_en_i     = 1'b0;
        rd_addr_i   = '0;
        mem_addr_i  = '0;
        mem_wdata_i = '0;
        ls_op_i     = OP_LW;
        mem_rd_i    = 1'b0;
        mem_wr_i    = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        check_val("wb_en_o in reset", 32'(wb_en_o), 32'h0);
        check_val("load_o in reset", 32'(load_o), 32'h0);
        check_val("load_valid_o in reset", 32'(load_valid_o), 32'h0);
        check_val("stall_o in reset", 32'(stall_o), 32'h0);
        check_val("gpio_o in reset", gpio_o, 32'h0);
        rst_i = 1'b1;
        // fill the test window so every load hits written data
        for (int w = 0; w < N_WORDS; w++) begin
            d = rand_bits(32);
            mem_model[w] = d;
            run_op(1'b0, 1'b1, {24'h0, 6'(w), 2'b00}, d, OP_SW, MEM_LATENCY, 32'h0);
        end
        io_access(1'b0, 1'b1);
        io_access(1'b0, 1'b0);
        io_access(1'b1, 1'b0);
        for (int n = 0; n < N_RANDOM; n++) begin
            case (3'(rand_bits(3)))
                3'd0: begin
                    a = rand_bits(32);
                    d = rand_bits(32);
                    run_op(1'b0, 1'b0, a, d, OP_LW, 0, 32'h0);
                end
                3'd1: begin
                    t = 1'(rand_bits(1));
                    io_access(t, 1'(rand_bits(1)));
                end
                default: random_mem_op();
            endcase
        end
        $display("Done: no errors");
        $finish;
    end

endmodule
